// ==== rtl/wd_fdc_pkg.sv ====
// wd_fdc_pkg
// host side definitions of the WD1793 style controller:
// register map, command codes, command and status bit positions
package wd_fdc_pkg;

	typedef logic [7:0] fdc_byte_t;   // register or data byte
	typedef logic [1:0] reg_addr_t;   // host register select

	localparam reg_addr_t A_CMD_STATUS = 2'd0;   // write: command, read: status
	localparam reg_addr_t A_TRACK      = 2'd1;
	localparam reg_addr_t A_SECTOR     = 2'd2;
	localparam reg_addr_t A_DATA       = 2'd3;

	// ==================================================================
	// command codes, top nibble of the command byte
	localparam logic [3:0] CMD_RESTORE   = 4'h0;
	localparam logic [3:0] CMD_SEEK      = 4'h1;
	localparam logic [3:0] CMD_STEP      = 4'h2;   // 2..3
	localparam logic [3:0] CMD_STEP_IN   = 4'h4;   // 4..5
	localparam logic [3:0] CMD_STEP_OUT  = 4'h6;   // 6..7
	localparam logic [3:0] CMD_READ      = 4'h8;   // 8..9
	localparam logic [3:0] CMD_WRITE     = 4'hA;   // A..B
	localparam logic [3:0] CMD_FORCE_INT = 4'hD;

	localparam int B_UPDATE = 4;   // steps: update track register
	localparam int B_MULTI  = 4;   // type II: run to end of track

	// status register bits
	localparam int ST_BUSY     = 0;
	localparam int ST_DRQ      = 1;   // type II mode
	localparam int ST_TRACK0   = 2;   // type I mode
	localparam int ST_SEEKERR  = 4;
	localparam int ST_WRFAULT  = 5;
	localparam int ST_WPROT    = 6;
	localparam int ST_NOTREADY = 7;

endpackage

// ==== rtl/wd_geom_pkg.sv ====
// wd_geom_pkg
// fixed disk geometry in track-side-sector order
// size codes 0..2 give 26x128, 16x256 and 9x512 per track side
package wd_geom_pkg;

	typedef logic [1:0]  size_code_t;   // sector size code
	typedef logic [7:0]  track_t;       // head track number
	typedef logic [31:0] lba_t;         // SD block number
	typedef logic [8:0]  buf_addr_t;    // byte within one block
	typedef logic [9:0]  sec_len_t;     // sector byte count, up to 512

	localparam int unsigned BLOCK_BYTES = 512;

	function automatic sec_len_t sector_bytes(input size_code_t code);
		case (code)
			2'd0:    return 10'd128;
			2'd1:    return 10'd256;
			default: return 10'd512;   // 3 falls back to 512
		endcase
	endfunction

	function automatic logic [7:0] sectors_per_track(input size_code_t code);
		case (code)
			2'd0:    return 8'd26;
			2'd1:    return 8'd16;
			default: return 8'd9;
		endcase
	endfunction

endpackage

// ==== rtl/wd_host_regs.sv ====
`timescale 1ns/1ps
// wd_host_regs
// host bus side of the controller: bus edge detection, track, sector
// and data registers, status assembly and the read data mux.
// raises cmd_strobe on every command write and flags the end of
// each data register access to the sequencer
module wd_host_regs (
	input  logic                  clk_sys,
	input  logic                  reset_spin,
	input  logic                  io_en,
	input  logic                  rd,
	input  logic                  wr,
	input  wd_fdc_pkg::reg_addr_t addr,
	input  wd_fdc_pkg::fdc_byte_t din,
	input  wd_fdc_pkg::fdc_byte_t buf_q,
	input  logic                  ready,
	input  logic                  wp,
	input  logic                  track_load,
	input  wd_geom_pkg::track_t   track_value,
	input  logic                  sector_inc,
	input  logic                  cmd_type1,
	input  logic                  busy,
	input  logic                  drq,
	input  logic                  seek_err,
	input  logic                  wr_fault,
	input  logic                  at_track0,
	input  logic                  intrq_set,
	output wd_fdc_pkg::fdc_byte_t dout,
	output logic                  intrq,
	output logic                  cmd_strobe,
	output wd_fdc_pkg::fdc_byte_t cmd_byte,
	output logic                  data_rd_done,
	output logic                  data_wr_done,
	output wd_geom_pkg::track_t   track_reg,
	output wd_fdc_pkg::fdc_byte_t sector_reg,
	output wd_fdc_pkg::fdc_byte_t data_reg
);

	logic                  rde, wre;
	logic                  old_rd, old_wr;
	logic                  wr_edge, rd_fall, wr_fall;
	wd_fdc_pkg::reg_addr_t cur_addr;   // register of the access in progress
	wd_fdc_pkg::fdc_byte_t status;

	assign rde     = rd & io_en;
	assign wre     = wr & io_en;
	assign wr_edge = wre & ~old_wr;
	assign rd_fall = old_rd & ~rde;
	assign wr_fall = old_wr & ~wre;

	assign cmd_strobe   = wr_edge && (addr == wd_fdc_pkg::A_CMD_STATUS);
	assign cmd_byte     = din;
	assign data_rd_done = rd_fall && (cur_addr == wd_fdc_pkg::A_DATA);
	assign data_wr_done = wr_fall && (cur_addr == wd_fdc_pkg::A_DATA);

	always_ff @(posedge clk_sys) begin
		if (reset_spin) begin
			old_rd     <= 1'b0;
			old_wr     <= 1'b0;
			cur_addr   <= wd_fdc_pkg::A_CMD_STATUS;
			intrq      <= 1'b0;
			track_reg  <= '0;
			sector_reg <= '0;
			data_reg   <= '0;
		end else begin
			old_rd <= rde;
			old_wr <= wre;
			if ((rde && !old_rd) || wr_edge)
				cur_addr <= addr;

			// set wins over both clears
			if (rd_fall && cur_addr == wd_fdc_pkg::A_CMD_STATUS)
				intrq <= 1'b0;
			if (cmd_strobe)
				intrq <= 1'b0;
			if (intrq_set)
				intrq <= 1'b1;

			if (track_load)
				track_reg <= track_value;
			if (sector_inc)
				sector_reg <= sector_reg + 8'd1;   // next sector in multi mode

			if (wr_edge) begin
				case (addr)
					wd_fdc_pkg::A_TRACK:  if (!busy) track_reg <= din;
					wd_fdc_pkg::A_SECTOR: if (!busy) sector_reg <= din;
					wd_fdc_pkg::A_DATA:   data_reg <= din;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		status = '0;
		status[wd_fdc_pkg::ST_BUSY]     = busy;
		status[wd_fdc_pkg::ST_SEEKERR]  = seek_err;
		status[wd_fdc_pkg::ST_WPROT]    = wp;
		status[wd_fdc_pkg::ST_NOTREADY] = ~ready;
		if (cmd_type1) begin
			status[wd_fdc_pkg::ST_TRACK0] = at_track0;   // head loaded, index stay 0
		end else begin
			status[wd_fdc_pkg::ST_DRQ]     = drq;
			status[wd_fdc_pkg::ST_WRFAULT] = wr_fault;
		end
	end

	always_comb begin
		case (addr)
			wd_fdc_pkg::A_CMD_STATUS: dout = status;
			wd_fdc_pkg::A_TRACK:      dout = track_reg;
			wd_fdc_pkg::A_SECTOR:     dout = sector_reg;
			default:                  dout = drq ? buf_q : data_reg;
		endcase
	end

endmodule

// ==== rtl/wd_cmd_seq.sv ====
`timescale 1ns/1ps
// wd_cmd_seq
// command sequencer: head positioning for type I commands, sector
// transfers for type II with SD block fetch and store, force interrupt,
// and the BUSY/DRQ/INTRQ and error flags
module wd_cmd_seq #(
	parameter int SETTLE_CYCLES = 64
) (
	input  logic                   clk_sys,
	input  logic                   reset_spin,
	input  logic                   cmd_strobe,
	input  wd_fdc_pkg::fdc_byte_t  cmd_byte,
	input  logic                   data_rd_done,
	input  logic                   data_wr_done,
	input  wd_fdc_pkg::fdc_byte_t  data_reg,
	input  wd_geom_pkg::track_t    track_reg,
	input  logic                   ready,
	input  logic                   wp,
	input  logic                   sector_ok,
	input  wd_geom_pkg::lba_t      blk_lba,
	input  wd_geom_pkg::buf_addr_t byte_offset,
	input  wd_geom_pkg::sec_len_t  sec_len,
	input  logic                   sd_ack,
	output wd_geom_pkg::track_t    head_track,
	output logic                   track_load,
	output wd_geom_pkg::track_t    track_value,
	output logic                   sector_inc,
	output logic                   cmd_type1,
	output logic                   busy,
	output logic                   drq,
	output logic                   seek_err,
	output logic                   wr_fault,
	output logic                   at_track0,
	output logic                   intrq_set,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output wd_geom_pkg::lba_t      sd_lba,
	output wd_geom_pkg::buf_addr_t host_buf_addr,
	output logic                   host_buf_we
);

	localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

	typedef enum logic [3:0] {
		st_idle, st_settle, st_search, st_fetch, st_fetch_wait,
		st_xfer, st_store, st_store_wait, st_next, st_end
	} seq_state_t;

	seq_state_t            state;
	logic [3:0]            cmd_nib;
	logic                  accept, cmd_is_write, step_out, byte_done;
	logic                  step_dir;   // last step direction, 1 = out
	logic                  is_write, multi;
	logic                  ack_seen;   // sd_ack seen high in this request
	logic                  map_wait;   // disk map lags its inputs by one cycle
	logic [CNT_W-1:0]      settle_cnt;
	wd_geom_pkg::sec_len_t byte_cnt;   // bytes left in the sector

	assign cmd_nib      = cmd_byte[7:4];
	assign accept       = cmd_strobe && (state == st_idle || cmd_nib == wd_fdc_pkg::CMD_FORCE_INT);
	assign cmd_is_write = cmd_nib[3:1] == wd_fdc_pkg::CMD_WRITE[3:1];
	assign step_out     = cmd_byte[6] ? cmd_byte[5] : step_dir;
	assign byte_done    = is_write ? data_wr_done : data_rd_done;

	assign at_track0   = (head_track == '0);
	assign intrq_set   = (state == st_end);
	assign sector_inc  = (state == st_next) && multi;
	assign host_buf_we = (state == st_xfer) && drq && is_write && data_wr_done;

	always_ff @(posedge clk_sys) begin
		if (reset_spin) begin
			state      <= st_idle;
			busy       <= 1'b0;
			drq        <= 1'b0;
			seek_err   <= 1'b0;
			wr_fault   <= 1'b0;
			cmd_type1  <= 1'b1;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			ack_seen   <= 1'b0;
			map_wait   <= 1'b0;
			head_track <= '0;
			step_dir   <= 1'b0;
			track_load <= 1'b0;
			is_write   <= 1'b0;
			multi      <= 1'b0;
		end else begin
			track_load <= 1'b0;
			case (state)
				st_idle: ;
				st_settle: begin
					settle_cnt <= settle_cnt + 1'b1;
					if (settle_cnt == CNT_W'(SETTLE_CYCLES))
						state <= st_end;
				end
				st_search: begin
					if (map_wait) begin
						map_wait <= 1'b0;
					end else if (!ready || !sector_ok) begin
						seek_err <= 1'b1;   // also ends a multi-sector run
						state    <= st_end;
					end else begin
						sd_lba        <= blk_lba;
						host_buf_addr <= byte_offset;
						byte_cnt      <= sec_len;
						state         <= st_fetch;
					end
				end
				st_fetch: begin
					sd_rd <= 1'b1;   // also read before write
					state <= st_fetch_wait;
				end
				st_fetch_wait, st_store_wait: begin
					if (sd_ack) begin
						sd_rd    <= 1'b0;
						sd_wr    <= 1'b0;
						ack_seen <= 1'b1;
					end else if (ack_seen) begin   // ack fell, block done
						ack_seen <= 1'b0;
						state    <= (state == st_fetch_wait) ? st_xfer : st_next;
					end
				end
				st_xfer: begin
					if (!drq) begin
						drq <= 1'b1;   // buf_q follows host_buf_addr by now
					end else if (byte_done) begin
						drq           <= 1'b0;
						byte_cnt      <= byte_cnt - 1'b1;
						host_buf_addr <= host_buf_addr + 1'b1;
						if (byte_cnt == wd_geom_pkg::sec_len_t'(1))
							state <= is_write ? st_store : st_next;
					end
				end
				st_store: begin
					sd_wr <= 1'b1;
					state <= st_store_wait;
				end
				st_next: begin
					if (multi) begin
						map_wait <= 1'b1;
						state    <= st_search;
					end else begin
						state <= st_end;
					end
				end
				st_end: begin
					busy  <= 1'b0;
					drq   <= 1'b0;
					sd_rd <= 1'b0;
					sd_wr <= 1'b0;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase

			// ==========================================================
			// command start, overrides the state machine above
			if (accept) begin
				case (cmd_nib)
					wd_fdc_pkg::CMD_RESTORE: begin
						head_track  <= '0;
						track_load  <= 1'b1;
						track_value <= '0;
					end
					wd_fdc_pkg::CMD_SEEK: begin
						head_track  <= data_reg;
						track_load  <= 1'b1;
						track_value <= data_reg;
					end
					wd_fdc_pkg::CMD_STEP, wd_fdc_pkg::CMD_STEP + 4'd1,
					wd_fdc_pkg::CMD_STEP_IN, wd_fdc_pkg::CMD_STEP_IN + 4'd1,
					wd_fdc_pkg::CMD_STEP_OUT, wd_fdc_pkg::CMD_STEP_OUT + 4'd1: begin
						if (cmd_byte[6])
							step_dir <= cmd_byte[5];   // remembered for plain step
						head_track  <= step_out ? head_track - 1'b1 : head_track + 1'b1;
						track_load  <= cmd_byte[wd_fdc_pkg::B_UPDATE];
						track_value <= step_out ? track_reg - 1'b1 : track_reg + 1'b1;
					end
					wd_fdc_pkg::CMD_READ, wd_fdc_pkg::CMD_READ + 4'd1,
					wd_fdc_pkg::CMD_WRITE, wd_fdc_pkg::CMD_WRITE + 4'd1: begin
						busy      <= 1'b1;
						cmd_type1 <= 1'b0;
						seek_err  <= 1'b0;
						wr_fault  <= 1'b0;
						is_write  <= cmd_is_write;
						multi     <= cmd_byte[wd_fdc_pkg::B_MULTI];
						if (cmd_is_write && wp) begin
							wr_fault <= 1'b1;
							state    <= st_end;
						end else begin
							map_wait <= 1'b1;
							state    <= st_search;
						end
					end
					wd_fdc_pkg::CMD_FORCE_INT: begin
						drq       <= 1'b0;
						sd_rd     <= 1'b0;
						sd_wr     <= 1'b0;
						ack_seen  <= 1'b0;
						cmd_type1 <= 1'b1;
						seek_err  <= 1'b0;
						wr_fault  <= 1'b0;
						state     <= st_end;
					end
					default: ;   // read address, read track, write track
				endcase
				if (!cmd_byte[7]) begin   // all type I share the settle time
					busy       <= 1'b1;
					cmd_type1  <= 1'b1;
					seek_err   <= 1'b0;
					wr_fault   <= 1'b0;
					settle_cnt <= '0;
					state      <= st_settle;
				end
			end
		end
	end

endmodule

// ==== rtl/wd_disk_map.sv ====
`timescale 1ns/1ps
// wd_disk_map
// maps head track, side and sector to an SD block and byte offset
// for the fixed track-side-sector image layout, and range checks
// the sector number. outputs lag the inputs by one clock
module wd_disk_map (
	input  logic                   clk_sys,
	input  wd_geom_pkg::track_t    head_track,
	input  logic                   side,
	input  wd_fdc_pkg::fdc_byte_t  sector_reg,
	input  wd_geom_pkg::size_code_t size_code,
	output wd_geom_pkg::lba_t      blk_lba,
	output wd_geom_pkg::buf_addr_t byte_offset,
	output logic                   sector_ok,
	output wd_geom_pkg::sec_len_t  sec_len
);

	logic [7:0]            spt;
	wd_geom_pkg::sec_len_t bytes;
	logic [31:0]           trk_side;   // track * 2 + side
	logic [31:0]           pos;        // byte position in the image

	always_comb begin
		spt      = wd_geom_pkg::sectors_per_track(size_code);
		bytes    = wd_geom_pkg::sector_bytes(size_code);
		trk_side = {23'd0, head_track, side};
		pos      = (trk_side * 32'(spt) + 32'(sector_reg) - 32'd1) * 32'(bytes);
	end

	// ==================================================================
	always_ff @(posedge clk_sys) begin
		blk_lba     <= pos / wd_geom_pkg::BLOCK_BYTES;
		byte_offset <= wd_geom_pkg::buf_addr_t'(pos % wd_geom_pkg::BLOCK_BYTES);
		sector_ok   <= (sector_reg != 8'd0) && (sector_reg <= spt);   // sectors count from 1
		sec_len     <= bytes;
	end

endmodule

// ==== rtl/wd_sector_buf.sv ====
`timescale 1ns/1ps
// wd_sector_buf
// one 512-byte block, true dual port with registered reads
// port a faces the SD device, port b the host byte transfer
module wd_sector_buf (
	input  logic                   clk_sys,
	input  wd_geom_pkg::buf_addr_t a_addr,
	input  wd_fdc_pkg::fdc_byte_t  a_wdata,
	input  logic                   a_we,
	output wd_fdc_pkg::fdc_byte_t  a_rdata,
	input  wd_geom_pkg::buf_addr_t b_addr,
	input  wd_fdc_pkg::fdc_byte_t  b_wdata,
	input  logic                   b_we,
	output wd_fdc_pkg::fdc_byte_t  b_rdata
);

	wd_fdc_pkg::fdc_byte_t mem [0:wd_geom_pkg::BLOCK_BYTES-1];

	always @(posedge clk_sys) begin
		if (a_we) begin
			mem[a_addr] <= a_wdata;
			a_rdata     <= a_wdata;   // write-through
		end else begin
			a_rdata <= mem[a_addr];
		end
	end

	always @(posedge clk_sys) begin
		if (b_we) begin
			mem[b_addr] <= b_wdata;
			b_rdata     <= b_wdata;
		end else begin
			b_rdata <= mem[b_addr];
		end
	end

endmodule

// ==== rtl/wd_fdc.sv ====
`timescale 1ns/1ps
// wd_fdc
// WD1793 style floppy controller on an SD block device
// host registers, command sequencer, disk map and sector buffer
module wd_fdc #(
	parameter int SETTLE_CYCLES = 64
) (
	input  logic                    clk_sys,
	input  logic                    reset_spin,
	input  logic                    io_en,
	input  logic                    rd,
	input  logic                    wr,
	input  wd_fdc_pkg::reg_addr_t   addr,
	input  wd_fdc_pkg::fdc_byte_t   din,
	output wd_fdc_pkg::fdc_byte_t   dout,
	output logic                    drq,
	output logic                    intrq,
	output logic                    busy,
	input  logic                    wp,
	input  logic                    ready,
	input  logic                    side,
	input  wd_geom_pkg::size_code_t size_code,
	output wd_geom_pkg::lba_t       sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	input  logic                    sd_ack,
	input  wd_geom_pkg::buf_addr_t  sd_buff_addr,
	input  wd_fdc_pkg::fdc_byte_t   sd_buff_dout,
	output wd_fdc_pkg::fdc_byte_t   sd_buff_din,
	input  logic                    sd_buff_wr
);

	wd_fdc_pkg::fdc_byte_t  buf_q, cmd_byte, sector_reg, data_reg;
	wd_geom_pkg::track_t    track_reg, track_value, head_track;
	wd_geom_pkg::lba_t      blk_lba;
	wd_geom_pkg::buf_addr_t byte_offset, host_buf_addr;
	wd_geom_pkg::sec_len_t  sec_len;
	logic cmd_strobe, data_rd_done, data_wr_done, track_load, sector_inc;
	logic cmd_type1, seek_err, wr_fault, at_track0, intrq_set, sector_ok, host_buf_we;

	wd_host_regs regs0 (.*);

	wd_cmd_seq #(.SETTLE_CYCLES(SETTLE_CYCLES)) seq0 (.*);

	wd_disk_map map0 (.*);

	wd_sector_buf buf0 (
		.clk_sys (clk_sys),
		.a_addr  (sd_buff_addr),
		.a_wdata (sd_buff_dout),
		.a_we    (sd_buff_wr & sd_ack),   // device writes only inside a request
		.a_rdata (sd_buff_din),
		.b_addr  (host_buf_addr),
		.b_wdata (data_reg),
		.b_we    (host_buf_we),
		.b_rdata (buf_q)
	);

endmodule

// ==== sim/wd_fdc_sva.sv ====
`timescale 1ns/1ps
// wd_fdc_sva
// bound checks on the SD request lines, DRQ against BUSY and
// the response to force interrupt
module wd_fdc_sva (
	input logic                  clk_sys,
	input logic                  reset_spin,
	input logic                  sd_rd,
	input logic                  sd_wr,
	input logic                  drq,
	input logic                  busy,
	input logic                  cmd_strobe,
	input wd_fdc_pkg::fdc_byte_t cmd_byte
);

	int fail_count = 0;

	a_one_request: assert property (@(posedge clk_sys) disable iff (reset_spin)
		!(sd_rd && sd_wr))
	else begin
		fail_count++;
		$error("sd_rd and sd_wr are high together");
	end

	a_drq_busy: assert property (@(posedge clk_sys) disable iff (reset_spin)
		drq |-> busy)
	else begin
		fail_count++;
		$error("drq is high while busy is low");
	end

	// force interrupt drops busy within two clocks
	a_force_int: assert property (@(posedge clk_sys) disable iff (reset_spin)
		(cmd_strobe && cmd_byte[7:4] == wd_fdc_pkg::CMD_FORCE_INT) |-> ##[1:2] !busy)
	else begin
		fail_count++;
		$error("busy still high two cycles after force interrupt");
	end

endmodule

bind wd_fdc wd_fdc_sva sva0 (.*);

// ==== sim/tb_wd_fdc.sv ====
`timescale 1ns/1ps
// tb_wd_fdc
// testbench for the WD1793 style controller: host bus tasks, an SD
// block device serving a random disk image, and a model of head
// position, track register and image layout for the random tests
module tb_wd_fdc;

	localparam int N_REG     = 3;
	localparam int N_TYPE1   = 16;
	localparam int N_READ    = 6;
	localparam int N_WRITE   = 4;
	localparam int NUM_TESTS = N_REG + N_TYPE1 + N_READ + N_WRITE + 4;
	localparam int CYCLE_LIMIT = NUM_TESTS * 4000;

	logic        clk_sys = 1'b0;
	logic        reset_spin, io_en, rd, wr, wp, ready, side;
	logic [1:0]  addr, size_code;
	logic [7:0]  din, sd_buff_dout;
	logic        sd_ack, sd_buff_wr;
	logic [8:0]  sd_buff_addr;
	wire  [7:0]  dout, sd_buff_din;
	wire         drq, intrq, busy, sd_rd, sd_wr;
	wire  [31:0] sd_lba;

	logic [7:0]  image [int unsigned];   // disk image, byte position keyed
	bit          req_kind [$];           // 0 read, 1 write
	int unsigned req_lba [$];
	logic [7:0]  model_head = 8'd0;
	logic [7:0]  model_trk = 8'd0;
	logic        model_dir = 1'b0;       // 1 = step out
	logic [1:0]  cur_code;
	logic        cur_side;
	int          n_checks = 0;
	int          n_errors = 0;
	int          cycles = 0;

	wd_fdc #(.SETTLE_CYCLES(64)) dut0 (.*);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERR %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// ==================================================================
	// image and geometry model
	function automatic logic [7:0] img_byte(input int unsigned pos);
		if (!image.exists(pos))
			image[pos] = 8'($urandom);   // filled on first touch
		return image[pos];
	endfunction

	function automatic int spt_of(input logic [1:0] code);
		return (code == 2'd0) ? 26 : (code == 2'd1) ? 16 : 9;
	endfunction

	function automatic int bytes_of(input logic [1:0] code);
		return 128 << code;
	endfunction

	function automatic int unsigned map_pos(input int sec);
		return ((int'(model_head) * 2 + int'(cur_side)) * spt_of(cur_code) + sec - 1)
			* bytes_of(cur_code);
	endfunction

	// ==================================================================
	// SD block device
	task automatic load_block(input int unsigned lba);
		int i;
		for (i = 0; i < 512; i++) begin
			sd_buff_addr = 9'(i);
			sd_buff_dout = img_byte(lba * 512 + i);
			sd_buff_wr   = 1'b1;
			@(negedge clk_sys);
		end
		sd_buff_wr = 1'b0;
	endtask

	task automatic store_block(input int unsigned lba);
		int i;
		sd_buff_addr = 9'd0;
		for (i = 0; i < 512; i++) begin
			@(negedge clk_sys);
			image[lba * 512 + i] = sd_buff_din;   // addressed one cycle ago
			sd_buff_addr = 9'(i + 1);
		end
	endtask

	initial begin : sd_device
		int unsigned lba;
		bit          is_wr;
		forever begin
			@(negedge clk_sys);
			if (!reset_spin && (sd_rd || sd_wr)) begin
				is_wr = sd_wr;
				lba   = sd_lba;
				req_kind.push_back(is_wr);
				req_lba.push_back(lba);
				repeat (1 + $urandom % 8) @(negedge clk_sys);   // ack delay
				sd_ack = 1'b1;
				if (is_wr)
					store_block(lba);
				else
					load_block(lba);
				check("sd_lba", sd_lba, lba);   // held for the whole request
				sd_ack = 1'b0;
			end
		end
	end

	// ==================================================================
	// host bus, entered and left just after a falling edge
	task automatic reg_write(input logic [1:0] a, input logic [7:0] d);
		io_en = 1'b1;
		wr    = 1'b1;
		addr  = a;
		din   = d;
		@(negedge clk_sys);
		wr    = 1'b0;
		io_en = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic reg_read(input logic [1:0] a, output logic [7:0] d);
		io_en = 1'b1;
		rd    = 1'b1;
		addr  = a;
		@(negedge clk_sys);
		d     = dout;
		rd    = 1'b0;
		io_en = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic wait_intrq();
		while (!intrq)
			@(negedge clk_sys);
	endtask

	task automatic wait_drq();
		while (!drq && !intrq)   // early end shows up as a drq error
			@(negedge clk_sys);
	endtask

	task automatic clear_requests();
		req_kind.delete();
		req_lba.delete();
	endtask

	task automatic seek_to(input logic [7:0] t);
		reg_write(wd_fdc_pkg::A_DATA, t);
		reg_write(wd_fdc_pkg::A_CMD_STATUS, 8'h10);
		wait_intrq();
		model_head = t;
		model_trk  = t;
	endtask

	task automatic pick_geometry();
		cur_code  = 2'($urandom % 3);
		cur_side  = 1'($urandom % 2);
		size_code = cur_code;
		side      = cur_side;
		seek_to(8'($urandom % 80));
	endtask

	// ==================================================================
	// tests
	task automatic regs_test();
		logic [7:0] t, s, d;
		t = 8'($urandom);
		s = 8'($urandom);
		reg_write(wd_fdc_pkg::A_TRACK, t);
		reg_write(wd_fdc_pkg::A_SECTOR, s);
		reg_read(wd_fdc_pkg::A_TRACK, d);
		check("track_reg", d, t);
		reg_read(wd_fdc_pkg::A_SECTOR, d);
		check("sector_reg", d, s);
		model_trk = t;
	endtask

	task automatic type1_test();
		logic [7:0] cmd, d, t;
		logic       upd, out;
		int         kind;
		kind = $urandom % 3;
		upd  = 1'($urandom % 2);
		if (kind == 0) begin   // restore
			cmd        = 8'h00;
			model_head = 8'd0;
			model_trk  = 8'd0;
		end else if (kind == 1) begin   // seek
			t = 8'($urandom % 80);
			reg_write(wd_fdc_pkg::A_DATA, t);
			cmd        = 8'h10;
			model_head = t;
			model_trk  = t;
		end else begin
			out = (model_head != 8'd0) && ($urandom % 2 == 1);   // never below track 0
			if (out == model_dir && $urandom % 2 == 1)
				cmd = {3'b001, upd, 4'h0};   // plain step, same direction
			else
				cmd = {2'b01, out, upd, 4'h0};
			model_dir  = out;
			model_head = out ? model_head - 8'd1 : model_head + 8'd1;
			if (upd)
				model_trk = out ? model_trk - 8'd1 : model_trk + 8'd1;
		end
		reg_write(wd_fdc_pkg::A_CMD_STATUS, cmd);
		wait_intrq();
		check("busy", busy, 1'b0);
		reg_read(wd_fdc_pkg::A_CMD_STATUS, d);
		check("status track0", d[2], model_head == 8'd0);
		check("status busy", d[0], 1'b0);
		reg_read(wd_fdc_pkg::A_TRACK, d);
		check("track_reg", d, model_trk);
	endtask

	task automatic read_run(input logic [7:0] first, input int count, input logic multi);
		logic [7:0]  d;
		int unsigned pos;
		int          s, i;
		reg_write(wd_fdc_pkg::A_SECTOR, first);
		clear_requests();
		reg_write(wd_fdc_pkg::A_CMD_STATUS, multi ? 8'h90 : 8'h80);
		for (s = 0; s < count; s++) begin
			pos = map_pos(int'(first) + s);
			for (i = 0; i < bytes_of(cur_code); i++) begin
				wait_drq();
				check("drq", drq, 1'b1);
				reg_read(wd_fdc_pkg::A_DATA, d);
				check("dout", d, img_byte(pos + i));
			end
		end
		wait_intrq();
		check("sd request count", req_kind.size(), count);
		if (req_kind.size() == count) begin
			for (s = 0; s < count; s++) begin
				check("sd_rd request", req_kind[s], 1'b0);
				check("sd_lba", req_lba[s], map_pos(int'(first) + s) / 512);
			end
		end
		reg_read(wd_fdc_pkg::A_CMD_STATUS, d);
		check("status seek error", d[4], multi);   // multi runs off the track
		check("status busy", d[0], 1'b0);
	endtask

	task automatic read_test();
		pick_geometry();
		read_run(8'(1 + $urandom % spt_of(cur_code)), 1, 1'b0);
	endtask

	task automatic write_test();
		logic [7:0]  exp_blk [512];
		logic [7:0]  d;
		int unsigned pos, lba, off;
		int          sec, n, i;
		pick_geometry();
		sec = 1 + $urandom % spt_of(cur_code);
		n   = bytes_of(cur_code);
		pos = map_pos(sec);
		lba = pos / 512;
		off = pos % 512;
		for (i = 0; i < 512; i++)
			exp_blk[i] = img_byte(lba * 512 + i);
		for (i = 0; i < n; i++)
			exp_blk[off + i] = 8'($urandom);   // new sector contents
		reg_write(wd_fdc_pkg::A_SECTOR, 8'(sec));
		clear_requests();
		reg_write(wd_fdc_pkg::A_CMD_STATUS, 8'hA0);
		for (i = 0; i < n; i++) begin
			wait_drq();
			check("drq", drq, 1'b1);
			reg_write(wd_fdc_pkg::A_DATA, exp_blk[off + i]);
		end
		wait_intrq();
		check("sd request count", req_kind.size(), 2);
		if (req_kind.size() == 2) begin
			check("sd_rd request", req_kind[0], 1'b0);
			check("sd_wr request", req_kind[1], 1'b1);
			check("sd_lba", req_lba[0], lba);
			check("sd_lba", req_lba[1], lba);
		end
		for (i = 0; i < 512; i++)
			check("sd_buff_din", image[lba * 512 + i], exp_blk[i]);
		reg_read(wd_fdc_pkg::A_CMD_STATUS, d);
		check("status write fault", d[5], 1'b0);
		check("status seek error", d[4], 1'b0);
	endtask

	task automatic reject_tests();
		logic [7:0] d;
		int         spt;
		pick_geometry();
		spt = spt_of(cur_code);
		reg_write(wd_fdc_pkg::A_SECTOR, ($urandom % 2) ? 8'd0 : 8'(spt + 1 + $urandom % 40));
		clear_requests();
		reg_write(wd_fdc_pkg::A_CMD_STATUS, 8'h80);
		wait_intrq();
		check("sd request count", req_kind.size(), 0);
		reg_read(wd_fdc_pkg::A_CMD_STATUS, d);
		check("status seek error", d[4], 1'b1);

		wp = 1'b1;
		reg_write(wd_fdc_pkg::A_SECTOR, 8'd1);
		clear_requests();
		reg_write(wd_fdc_pkg::A_CMD_STATUS, 8'hA0);
		wait_intrq();
		check("sd request count", req_kind.size(), 0);
		reg_read(wd_fdc_pkg::A_CMD_STATUS, d);
		check("status write fault", d[5], 1'b1);
		check("status write protect", d[6], 1'b1);
		wp = 1'b0;

		read_run(8'(spt - 1), 2, 1'b1);   // last two sectors, then off the end
	endtask

	task automatic force_test();
		logic [7:0]  d;
		int unsigned pos;
		int          sec, i;
		pick_geometry();
		sec = 1 + $urandom % spt_of(cur_code);
		pos = map_pos(sec);
		reg_write(wd_fdc_pkg::A_SECTOR, 8'(sec));
		reg_write(wd_fdc_pkg::A_CMD_STATUS, 8'h80);
		for (i = 0; i < 3; i++) begin
			wait_drq();
			reg_read(wd_fdc_pkg::A_DATA, d);
			check("dout", d, img_byte(pos + i));
		end
		wait_drq();
		reg_write(wd_fdc_pkg::A_CMD_STATUS, 8'hD0);
		check("busy", busy, 1'b0);
		check("drq", drq, 1'b0);
		check("intrq", intrq, 1'b1);
		reg_read(wd_fdc_pkg::A_CMD_STATUS, d);
		check("intrq", intrq, 1'b0);   // cleared by the status read
		check("status busy", d[0], 1'b0);
	endtask

	// ==================================================================
	initial begin : main
		int t;
		reset_spin   = 1'b1;
		io_en        = 1'b0;
		rd           = 1'b0;
		wr           = 1'b0;
		addr         = 2'd0;
		din          = 8'd0;
		wp           = 1'b0;
		ready        = 1'b1;
		side         = 1'b0;
		size_code    = 2'd0;
		sd_ack       = 1'b0;
		sd_buff_addr = 9'd0;
		sd_buff_dout = 8'd0;
		sd_buff_wr   = 1'b0;
		void'($urandom(32'h2e0c));
		repeat (16) @(negedge clk_sys);
		reset_spin = 1'b0;
		check("busy", busy, 1'b0);
		check("drq", drq, 1'b0);
		check("intrq", intrq, 1'b0);
		check("sd_rd", sd_rd, 1'b0);
		check("sd_wr", sd_wr, 1'b0);

		for (t = 0; t < N_REG; t++)
			regs_test();
		for (t = 0; t < N_TYPE1; t++)
			type1_test();
		for (t = 0; t < N_READ; t++)
			read_test();
		for (t = 0; t < N_WRITE; t++)
			write_test();
		reject_tests();
		force_test();

		$display("checks: %0d  errors: %0d  assertion failures: %0d",
			n_checks, n_errors, dut0.sva0.fail_count);
		if (n_errors == 0 && dut0.sva0.fail_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== wd_fdc.f ====
rtl/wd_fdc_pkg.sv
rtl/wd_geom_pkg.sv
rtl/wd_host_regs.sv
rtl/wd_cmd_seq.sv
rtl/wd_disk_map.sv
rtl/wd_sector_buf.sv
rtl/wd_fdc.sv
sim/wd_fdc_sva.sv
sim/tb_wd_fdc.sv
